/* common/axi_w_pkg.sv */
`default_nettype none

package axi_w_pkg;

	// Bus widths
	parameter int ADDR_W = 32;
	parameter int DATA_W = 64;
	parameter int STRB_W = DATA_W / 8;
	parameter int ID_W = 4;
	parameter int LEN_W = 8; // Beats minus one

	// Byte offset bits inside one data word
	parameter int BYTE_OFF_W = $clog2(STRB_W);

	// Bytes per beat, AXI AxSIZE coding
	typedef enum logic [2:0] {
		SIZE_1 = 3'd0,
		SIZE_2 = 3'd1,
		SIZE_4 = 3'd2,
		SIZE_8 = 3'd3
	} size_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'd0,
		RESP_EXOKAY = 2'd1,
		RESP_SLVERR = 2'd2,
		RESP_DECERR = 2'd3
	} resp_e;

	// Write master FSM
	typedef enum logic [1:0] {
		W_IDLE = 2'd0,
		W_ADDR = 2'd1, // AW offered
		W_DATA = 2'd2, // W beats
		W_RESP = 2'd3  // Waiting for B
	} mst_state_e;

	// SRAM slave FSM
	typedef enum logic [1:0] {
		S_IDLE = 2'd0,
		S_DATA = 2'd1,
		S_RESP = 2'd2
	} slv_state_e;

endpackage

`default_nettype wire

/* common/axi_w_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface axi_w_if;

	// AW channel
	logic                          aw_valid;
	logic                          aw_ready;
	logic [axi_w_pkg::ID_W-1:0]    aw_id;
	logic [axi_w_pkg::ADDR_W-1:0]  aw_addr;
	logic [axi_w_pkg::LEN_W-1:0]   aw_len;
	axi_w_pkg::size_e              aw_size;

	// W channel
	logic                          w_valid;
	logic                          w_ready;
	logic [axi_w_pkg::DATA_W-1:0]  w_data;
	logic [axi_w_pkg::STRB_W-1:0]  w_strb;
	logic                          w_last;

	// B channel
	logic                          b_valid;
	logic                          b_ready;
	logic [axi_w_pkg::ID_W-1:0]    b_id;
	axi_w_pkg::resp_e              b_resp;

	modport master (
		output aw_valid, aw_id, aw_addr, aw_len, aw_size,
		input  aw_ready,
		output w_valid, w_data, w_strb, w_last,
		input  w_ready,
		input  b_valid, b_id, b_resp,
		output b_ready
	);

	modport slave (
		input  aw_valid, aw_id, aw_addr, aw_len, aw_size,
		output aw_ready,
		input  w_valid, w_data, w_strb, w_last,
		output w_ready,
		output b_valid, b_id, b_resp,
		input  b_ready
	);

endinterface

`default_nettype wire

/* axi_w/axi_w_master.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_w_master (
	input  logic                          clk,
	input  logic                          reset_n,

	// Core store request
	input  logic                          cpu_aw_valid_i,
	input  logic [axi_w_pkg::ID_W-1:0]    cpu_id_i,
	input  logic [axi_w_pkg::ADDR_W-1:0]  cpu_addr_i,
	input  logic [axi_w_pkg::DATA_W-1:0]  cpu_data_i,
	input  logic [axi_w_pkg::LEN_W-1:0]   cpu_len_i,
	input  axi_w_pkg::size_e              cpu_size_i,
	output logic                          cpu_aw_ready_o,
	output logic                          cpu_w_done_o,
	output axi_w_pkg::resp_e              cpu_w_resp_o,

	axi_w_if.master                       bus
);

	axi_w_pkg::mst_state_e state_q;
	axi_w_pkg::mst_state_e state_d;

	logic                          accept;
	logic                          aw_fire;
	logic                          w_fire;
	logic                          b_fire;

	logic [axi_w_pkg::LEN_W-1:0]   beat_cnt_q;
	logic [axi_w_pkg::ADDR_W-1:0]  beat_addr_q;
	logic [axi_w_pkg::ADDR_W-1:0]  beat_bytes;
	logic [axi_w_pkg::STRB_W-1:0]  lane_mask;

	assign cpu_aw_ready_o = (state_q == axi_w_pkg::W_IDLE);
	assign accept         = cpu_aw_valid_i && cpu_aw_ready_o;

	assign aw_fire = bus.aw_valid && bus.aw_ready;
	assign w_fire  = bus.w_valid && bus.w_ready;
	assign b_fire  = bus.b_valid && bus.b_ready;

	// Valids come straight from the state register
	assign bus.aw_valid = (state_q == axi_w_pkg::W_ADDR);
	assign bus.w_valid  = (state_q == axi_w_pkg::W_DATA);
	assign bus.b_ready  = (state_q == axi_w_pkg::W_RESP);

	// Request is held by the core until done
	assign bus.aw_id   = cpu_id_i;
	assign bus.aw_addr = cpu_addr_i;
	assign bus.aw_len  = cpu_len_i;
	assign bus.aw_size = cpu_size_i;

	assign bus.w_data = cpu_data_i; // Same word on every beat
	assign bus.w_last = (beat_cnt_q == cpu_len_i);

	// 1, 2, 4 or 8 bytes per beat
	assign beat_bytes = {{(axi_w_pkg::ADDR_W-1){1'b0}}, 1'b1} << cpu_size_i;

	// Low beat_bytes lanes shifted to the beat's byte offset
	assign lane_mask  = ~({axi_w_pkg::STRB_W{1'b1}} << beat_bytes);
	assign bus.w_strb = lane_mask << beat_addr_q[axi_w_pkg::BYTE_OFF_W-1:0];

	always_comb begin
		state_d = state_q;
		case (state_q)
			axi_w_pkg::W_IDLE: begin
				if (accept)
					state_d = axi_w_pkg::W_ADDR;
			end
			axi_w_pkg::W_ADDR: begin
				if (aw_fire)
					state_d = axi_w_pkg::W_DATA;
			end
			axi_w_pkg::W_DATA: begin
				if (w_fire && bus.w_last)
					state_d = axi_w_pkg::W_RESP;
			end
			axi_w_pkg::W_RESP: begin
				if (b_fire)
					state_d = axi_w_pkg::W_IDLE;
			end
			default: state_d = axi_w_pkg::W_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state_q <= axi_w_pkg::W_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Beat counter cleared after the last beat
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			beat_cnt_q <= '0;
		end else if (accept) begin
			beat_cnt_q <= '0;
		end else if (w_fire) begin
			if (bus.w_last)
				beat_cnt_q <= '0;
			else
				beat_cnt_q <= beat_cnt_q + 1'b1;
		end
	end

	// Address of the current W beat
	always_ff @(posedge clk) begin
		if (accept)
			beat_addr_q <= cpu_addr_i;
		else if (w_fire)
			beat_addr_q <= beat_addr_q + beat_bytes;
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cpu_w_done_o <= 1'b0;
		end else begin
			cpu_w_done_o <= b_fire; // One cycle pulse
		end
	end

	always_ff @(posedge clk) begin
		if (b_fire)
			cpu_w_resp_o <= bus.b_resp;
	end

	a_beat_cnt_range: assert property (@(posedge clk) disable iff (!reset_n)
		(state_q != axi_w_pkg::W_IDLE) |-> (beat_cnt_q <= cpu_len_i));

	// The slave must echo the id of the request
	a_b_id_match: assert property (@(posedge clk) disable iff (!reset_n)
		b_fire |-> (bus.b_id == cpu_id_i));

endmodule

`default_nettype wire

/* mem/axi_sram_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_sram_slave #(
	parameter int MEM_WORDS = 256
) (
	input  logic                          clk,
	input  logic                          reset_n,

	axi_w_if.slave                        bus,

	// Observation port, one cycle latency
	input  logic [$clog2(MEM_WORDS)-1:0]  rd_addr_i,
	output logic [axi_w_pkg::DATA_W-1:0]  rd_data_o
);

	localparam int IDX_W = $clog2(MEM_WORDS);
	localparam logic [axi_w_pkg::ADDR_W-1:0] MEM_LIMIT = MEM_WORDS;

	logic [axi_w_pkg::DATA_W-1:0]  mem [MEM_WORDS];

	axi_w_pkg::slv_state_e state_q;

	logic                          aw_fire;
	logic                          w_fire;
	logic                          b_fire;
	logic                          in_range;
	logic [IDX_W-1:0]              wr_idx;
	logic [axi_w_pkg::ADDR_W-1:0]  beat_bytes;

	// Burst context latched on AW
	logic [axi_w_pkg::ADDR_W-1:0]  addr_q;
	axi_w_pkg::size_e              size_q;
	logic [axi_w_pkg::ID_W-1:0]    id_q;
	logic [axi_w_pkg::LEN_W-1:0]   len_q;
	logic [axi_w_pkg::LEN_W-1:0]   beat_cnt_q;
	logic                          err_q;

	assign bus.aw_ready = (state_q == axi_w_pkg::S_IDLE);
	assign bus.w_ready  = (state_q == axi_w_pkg::S_DATA);
	assign bus.b_valid  = (state_q == axi_w_pkg::S_RESP);
	assign bus.b_id     = id_q;
	assign bus.b_resp   = err_q ? axi_w_pkg::RESP_SLVERR : axi_w_pkg::RESP_OKAY;

	assign aw_fire = bus.aw_valid && bus.aw_ready;
	assign w_fire  = bus.w_valid && bus.w_ready;
	assign b_fire  = bus.b_valid && bus.b_ready;

	assign beat_bytes = {{(axi_w_pkg::ADDR_W-1){1'b0}}, 1'b1} << size_q;
	assign in_range   = (addr_q >> axi_w_pkg::BYTE_OFF_W) < MEM_LIMIT;
	assign wr_idx     = addr_q[axi_w_pkg::BYTE_OFF_W +: IDX_W];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state_q <= axi_w_pkg::S_IDLE;
		end else begin
			case (state_q)
				axi_w_pkg::S_IDLE: begin
					if (aw_fire)
						state_q <= axi_w_pkg::S_DATA;
				end
				axi_w_pkg::S_DATA: begin
					if (w_fire && bus.w_last)
						state_q <= axi_w_pkg::S_RESP;
				end
				axi_w_pkg::S_RESP: begin
					if (b_fire)
						state_q <= axi_w_pkg::S_IDLE;
				end
				default: state_q <= axi_w_pkg::S_IDLE;
			endcase
		end
	end

	// Beat address walks by the transfer size
	always_ff @(posedge clk) begin
		if (aw_fire) begin
			addr_q <= bus.aw_addr;
			size_q <= bus.aw_size;
			id_q   <= bus.aw_id;
			len_q  <= bus.aw_len;
		end else if (w_fire) begin
			addr_q <= addr_q + beat_bytes;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			beat_cnt_q <= '0;
			err_q      <= 1'b0;
		end else if (aw_fire) begin
			beat_cnt_q <= '0;
			err_q      <= 1'b0;
		end else if (w_fire) begin
			beat_cnt_q <= beat_cnt_q + 1'b1;
			if (!in_range)
				err_q <= 1'b1; // Sticky until next burst
		end
	end

	// Byte lane writes, out of range beats dropped
	always_ff @(posedge clk) begin
		if (w_fire && in_range) begin
			for (int b = 0; b < axi_w_pkg::STRB_W; b++) begin
				if (bus.w_strb[b])
					mem[wr_idx][b*8 +: 8] <= bus.w_data[b*8 +: 8];
			end
		end
		rd_data_o <= mem[rd_addr_i];
	end

	// Master must close the burst on beat len+1 and not before
	a_w_last_on_len: assert property (@(posedge clk) disable iff (!reset_n)
		w_fire |-> (bus.w_last == (beat_cnt_q == len_q)));

endmodule

`default_nettype wire

/* hdl/axi_w_top.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_w_top #(
	parameter int MEM_WORDS = 256
) (
	input  logic                          clk,
	input  logic                          reset_n,

	// Core side
	input  logic                          cpu_aw_valid_i,
	input  logic [axi_w_pkg::ID_W-1:0]    cpu_id_i,
	input  logic [axi_w_pkg::ADDR_W-1:0]  cpu_addr_i,
	input  logic [axi_w_pkg::DATA_W-1:0]  cpu_data_i,
	input  logic [axi_w_pkg::LEN_W-1:0]   cpu_len_i,
	input  axi_w_pkg::size_e              cpu_size_i,
	output logic                          cpu_aw_ready_o,
	output logic                          cpu_w_done_o,
	output axi_w_pkg::resp_e              cpu_w_resp_o,

	// RAM observation
	input  logic [$clog2(MEM_WORDS)-1:0]  rd_addr_i,
	output logic [axi_w_pkg::DATA_W-1:0]  rd_data_o
);

	axi_w_if bus_if ();

	axi_w_master u_master (
		.clk            (clk),
		.reset_n        (reset_n),
		.cpu_aw_valid_i (cpu_aw_valid_i),
		.cpu_id_i       (cpu_id_i),
		.cpu_addr_i     (cpu_addr_i),
		.cpu_data_i     (cpu_data_i),
		.cpu_len_i      (cpu_len_i),
		.cpu_size_i     (cpu_size_i),
		.cpu_aw_ready_o (cpu_aw_ready_o),
		.cpu_w_done_o   (cpu_w_done_o),
		.cpu_w_resp_o   (cpu_w_resp_o),
		.bus            (bus_if.master)
	);

	axi_sram_slave #(
		.MEM_WORDS (MEM_WORDS)
	) u_sram (
		.clk       (clk),
		.reset_n   (reset_n),
		.bus       (bus_if.slave),
		.rd_addr_i (rd_addr_i),
		.rd_data_o (rd_data_o)
	);

endmodule

`default_nettype wire

/* verif/axi_w_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_w_tb;

	localparam int MEM_WORDS = 256;
	localparam int IDX_W = $clog2(MEM_WORDS);
	localparam int STRB_W = axi_w_pkg::STRB_W;
	localparam int N_REQ = 9;
	localparam int MAX_BEATS = 6; // Longest burst in the table
	// Fill pass and table requests with slack for reads
	localparam int WATCHDOG_NS = (MEM_WORDS + N_REQ) * (20 + MAX_BEATS) * 8;

	typedef struct packed {
		logic [axi_w_pkg::ADDR_W-1:0] addr;
		axi_w_pkg::size_e             size;
		logic [axi_w_pkg::LEN_W-1:0]  len;
		axi_w_pkg::resp_e             resp;
	} req_t;

	logic                          clk;
	logic                          reset_n;
	logic                          cpu_aw_valid_i;
	logic [axi_w_pkg::ID_W-1:0]    cpu_id_i;
	logic [axi_w_pkg::ADDR_W-1:0]  cpu_addr_i;
	logic [axi_w_pkg::DATA_W-1:0]  cpu_data_i;
	logic [axi_w_pkg::LEN_W-1:0]   cpu_len_i;
	axi_w_pkg::size_e              cpu_size_i;
	logic                          cpu_aw_ready_o;
	logic                          cpu_w_done_o;
	axi_w_pkg::resp_e              cpu_w_resp_o;
	logic [IDX_W-1:0]              rd_addr_i;
	logic [axi_w_pkg::DATA_W-1:0]  rd_data_o;

	req_t        req_tbl [N_REQ];
	logic [7:0]  model_mem [MEM_WORDS*STRB_W]; // Byte-level copy of the RAM
	logic [31:0] lfsr_q;

	axi_w_top #(
		.MEM_WORDS (MEM_WORDS)
	) dut_i (
		.clk            (clk),
		.reset_n        (reset_n),
		.cpu_aw_valid_i (cpu_aw_valid_i),
		.cpu_id_i       (cpu_id_i),
		.cpu_addr_i     (cpu_addr_i),
		.cpu_data_i     (cpu_data_i),
		.cpu_len_i      (cpu_len_i),
		.cpu_size_i     (cpu_size_i),
		.cpu_aw_ready_o (cpu_aw_ready_o),
		.cpu_w_done_o   (cpu_w_done_o),
		.cpu_w_resp_o   (cpu_w_resp_o),
		.rd_addr_i      (rd_addr_i),
		.rd_data_o      (rd_data_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	initial begin
		#(WATCHDOG_NS);
		abort_run("Timeout, the DUT stopped answering requests");
	end

	task automatic check_resp(input string name, input axi_w_pkg::resp_e got,
		input axi_w_pkg::resp_e exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED at %0t ns: %s got %s expected %s",
				$time, name, got.name(), exp.name()));
	endtask

	task automatic check_word(input string name, input logic [axi_w_pkg::DATA_W-1:0] got,
		input logic [axi_w_pkg::DATA_W-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED at %0t ns: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED at %0t ns: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic next_rand_word(output logic [axi_w_pkg::DATA_W-1:0] w);
		for (int i = 0; i < axi_w_pkg::DATA_W; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			w = {w[axi_w_pkg::DATA_W-2:0], lfsr_q[0]};
		end
	endtask

	function automatic logic [axi_w_pkg::DATA_W-1:0] model_word(input int w);
		logic [axi_w_pkg::DATA_W-1:0] v;
		for (int b = 0; b < STRB_W; b++)
			v[b*8 +: 8] = model_mem[w*STRB_W + b];
		return v;
	endfunction

	// Beat k sits at start + k*size with lanes from that address
	task automatic model_write(input logic [31:0] addr, input axi_w_pkg::size_e size,
		input logic [7:0] len, input logic [axi_w_pkg::DATA_W-1:0] data);
		int nbytes;
		int lane;
		logic [31:0] a;
		nbytes = 1 << size;
		for (int k = 0; k <= int'(len); k++) begin
			for (int j = 0; j < nbytes; j++) begin
				a = addr + 32'(k * nbytes + j);
				lane = int'(a % STRB_W);
				if (a < 32'(MEM_WORDS * STRB_W))
					model_mem[a] = data[lane*8 +: 8];
			end
		end
	endtask

	// Entered and left on a falling edge
	task automatic run_request(input req_t r, input logic [axi_w_pkg::DATA_W-1:0] data);
		while (!cpu_aw_ready_o)
			@(negedge clk);
		cpu_aw_valid_i = 1'b1;
		cpu_id_i       = cpu_id_i + 1'b1;
		cpu_addr_i     = r.addr;
		cpu_size_i     = r.size;
		cpu_len_i      = r.len;
		cpu_data_i     = data;
		@(negedge clk);
		cpu_aw_valid_i = 1'b0;
		while (!cpu_w_done_o) begin
			check_flag("cpu_aw_ready_o", cpu_aw_ready_o, 1'b0); // Busy until done
			@(negedge clk);
		end
		check_flag("cpu_aw_ready_o", cpu_aw_ready_o, 1'b1);
		check_resp("cpu_w_resp_o", cpu_w_resp_o, r.resp);
		model_write(r.addr, r.size, r.len, data);
	endtask

	task automatic compare_word(input int w);
		rd_addr_i = IDX_W'(w);
		@(negedge clk);
		check_flag("cpu_w_done_o", cpu_w_done_o, 1'b0); // Done is a single cycle pulse
		check_word($sformatf("rd_data_o[%0d]", w), rd_data_o, model_word(w));
	endtask

	// Touched words and one neighbour on each side within the RAM
	task automatic compare_range(input req_t r);
		int first;
		int last;
		first = int'(r.addr) / STRB_W - 1;
		last  = (int'(r.addr) + (int'(r.len) + 1) * (1 << r.size) - 1) / STRB_W + 1;
		if (first < 0)
			first = 0;
		if (last > MEM_WORDS - 1)
			last = MEM_WORDS - 1;
		for (int w = first; w <= last; w++)
			compare_word(w);
	endtask

	initial begin
		logic [axi_w_pkg::DATA_W-1:0] data;
		req_t fill;
		reset_n        = 1'b0;
		cpu_aw_valid_i = 1'b0;
		cpu_id_i       = '0;
		cpu_addr_i     = '0;
		cpu_data_i     = '0;
		cpu_len_i      = '0;
		cpu_size_i     = axi_w_pkg::SIZE_1;
		rd_addr_i      = '0;
		lfsr_q         = 32'h30f0f908;

		req_tbl[0] = '{32'h041, axi_w_pkg::SIZE_1, 8'd0, axi_w_pkg::RESP_OKAY};
		req_tbl[1] = '{32'h04a, axi_w_pkg::SIZE_2, 8'd0, axi_w_pkg::RESP_OKAY};
		req_tbl[2] = '{32'h054, axi_w_pkg::SIZE_4, 8'd0, axi_w_pkg::RESP_OKAY};
		req_tbl[3] = '{32'h058, axi_w_pkg::SIZE_8, 8'd0, axi_w_pkg::RESP_OKAY};
		req_tbl[4] = '{32'h065, axi_w_pkg::SIZE_1, 8'd5, axi_w_pkg::RESP_OKAY};
		req_tbl[5] = '{32'h084, axi_w_pkg::SIZE_4, 8'd4, axi_w_pkg::RESP_OKAY};
		req_tbl[6] = '{32'h0c0, axi_w_pkg::SIZE_8, 8'd3, axi_w_pkg::RESP_OKAY};
		req_tbl[7] = '{32'h7f0, axi_w_pkg::SIZE_8, 8'd3, axi_w_pkg::RESP_SLVERR}; // Past word 255
		req_tbl[8] = '{32'h7f8, axi_w_pkg::SIZE_4, 8'd3, axi_w_pkg::RESP_SLVERR};

		repeat (4) @(negedge clk);
		reset_n = 1'b1;
		@(negedge clk);
		check_flag("cpu_aw_ready_o", cpu_aw_ready_o, 1'b1);
		check_flag("cpu_w_done_o", cpu_w_done_o, 1'b0);

		// Every word gets its own value before the table runs
		for (int w = 0; w < MEM_WORDS; w++) begin
			fill = '{32'(w * STRB_W), axi_w_pkg::SIZE_8, 8'd0, axi_w_pkg::RESP_OKAY};
			data = {~32'(w), 32'(w) ^ 32'h00c3_5a00};
			run_request(fill, data);
		end

		for (int i = 0; i < N_REQ; i++) begin
			next_rand_word(data);
			run_request(req_tbl[i], data);
			compare_range(req_tbl[i]);
		end

		for (int w = 0; w < MEM_WORDS; w++)
			compare_word(w);

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
common/axi_w_pkg.sv
common/axi_w_if.sv
axi_w/axi_w_master.sv
mem/axi_sram_slave.sv
hdl/axi_w_top.sv
verif/axi_w_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module axi_w_tb -o axi_w_sim

out=$(./obj_dir/axi_w_sim 2>&1 || true)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
